// File: src/skirocAcqPkg.sv
package skirocAcqPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    localparam int PhaseCntWidth = 20;    // Phase durations and phase timer
    localparam int WbAdrWidth    = 4;     // Word address
    localparam int WbDataWidth   = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer phases, code is reported in STATUS[3:0]

    typedef enum logic [3:0] {
        Idle          = 4'd0,
        Reset         = 4'd1,
        WaitToAcq     = 4'd2,
        Acquire       = 4'd3,
        WaitToConvB   = 4'd4,
        ConvB         = 4'd5,
        WaitToReadout = 4'd6,
        Readout       = 4'd7,
        WaitToEnd     = 4'd8,
        WaitToNext    = 4'd9
    } acqPhaseT;

    // Programmed durations, a value N means N+1 cycles
    typedef struct packed {
        logic [PhaseCntWidth-1:0] resetTime;
        logic [PhaseCntWidth-1:0] waitToAcq;
        logic [PhaseCntWidth-1:0] waitToConvB;
        logic [PhaseCntWidth-1:0] convBWidth;
        logic [PhaseCntWidth-1:0] waitToReadout;
        logic [PhaseCntWidth-1:0] readoutWidth;
        logic [PhaseCntWidth-1:0] waitToEnd;
        logic [PhaseCntWidth-1:0] waitToNext;
    } phaseCfgT;

    // SKIROC2 control pins
    typedef struct packed {
        logic startAcq;
        logic startConvB;     // Active low
        logic startReadout;
        logic pwrOnD;
        logic resetB;         // Active low
    } asicCtrlT;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone classic, configuration port

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [WbAdrWidth-1:0]  adr;
        logic [WbDataWidth-1:0] dat;
    } wbReqT;

    typedef struct packed {
        logic                   ack;
        logic [WbDataWidth-1:0] dat;
    } wbRspT;

    // Register map, word addresses
    localparam logic [WbAdrWidth-1:0] RegCtrl          = 4'd0;
    localparam logic [WbAdrWidth-1:0] RegStatus        = 4'd1;
    localparam logic [WbAdrWidth-1:0] RegResetTime     = 4'd2;
    localparam logic [WbAdrWidth-1:0] RegWaitToAcq     = 4'd3;
    localparam logic [WbAdrWidth-1:0] RegWaitToConvB   = 4'd4;
    localparam logic [WbAdrWidth-1:0] RegConvBWidth    = 4'd5;
    localparam logic [WbAdrWidth-1:0] RegWaitToReadout = 4'd6;
    localparam logic [WbAdrWidth-1:0] RegReadoutWidth  = 4'd7;
    localparam logic [WbAdrWidth-1:0] RegWaitToEnd     = 4'd8;
    localparam logic [WbAdrWidth-1:0] RegWaitToNext    = 4'd9;

endpackage

// File: src/edgeSync.sv
`timescale 1ns/1ns

// Brings one ASIC line into the Clk domain and flags its edges
module edgeSync #(
    parameter logic IdleLevel = 1'b0      // Level the line rests at
) (
    input  logic Clk,
    input  logic Rst_N,
    input  logic Async,
    output logic Rise,
    output logic Fall
);

    logic syncMeta;     // First stage, may go metastable
    logic syncStable;
    logic syncLast;     // Stable level one cycle earlier

    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
        begin
            syncMeta   <= IdleLevel;
            syncStable <= IdleLevel;
            syncLast   <= IdleLevel;
        end
        else
        begin
            syncMeta   <= Async;
            syncStable <= syncMeta;
            syncLast   <= syncStable;
        end
    end

    // Stable stage differs from its last level for a single cycle per change
    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
        begin
            Rise <= 1'b0;
            Fall <= 1'b0;
        end
        else
        begin
            Rise <= syncStable & ~syncLast;
            Fall <= ~syncStable & syncLast;
        end
    end

endmodule

// File: src/timingRegs.sv
`timescale 1ns/1ns

module timingRegs
    import skirocAcqPkg::*;
#(
    parameter logic [PhaseCntWidth-1:0] ResetTime         = 20'd25,
    parameter logic [PhaseCntWidth-1:0] WaitToAcqTime     = 20'd50,
    parameter logic [PhaseCntWidth-1:0] WaitToConvBTime   = 20'd50,
    parameter logic [PhaseCntWidth-1:0] ConvBWidth        = 20'd2,
    parameter logic [PhaseCntWidth-1:0] WaitToReadoutTime = 20'd250000,
    parameter logic [PhaseCntWidth-1:0] ReadoutWidth      = 20'd25,
    parameter logic [PhaseCntWidth-1:0] WaitToEndTime     = 20'd250000,
    parameter logic [PhaseCntWidth-1:0] WaitToNextTime    = 20'd50
) (
    input  logic     Clk,
    input  logic     Rst_N,
    input  wbReqT    WbReq,
    output wbRspT    WbRsp,
    input  acqPhaseT Phase,
    input  logic     Acqing,
    output logic     StartWork,
    output phaseCfgT PhaseCfg
);

    logic                   reqValid;
    logic                   ackQ;
    logic                   ackOut;
    logic                   wrEn;
    logic [WbDataWidth-1:0] rdMux;
    logic [WbDataWidth-1:0] rdData;

    ////////////////////////////////////////////////////////////////////////////
    // Bus handshake

    assign reqValid = WbReq.cyc & WbReq.stb;

    // One ack per access, cleared right after
    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
            ackQ <= 1'b0;
        else
            ackQ <= reqValid & ~ackQ;
    end

    assign ackOut = ackQ & reqValid;          // Withdrawn request kills ack
    assign wrEn   = ackOut & WbReq.we;

    assign WbRsp.ack = ackOut;
    assign WbRsp.dat = rdData;

    ////////////////////////////////////////////////////////////////////////////
    // Control and duration registers

    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
        begin
            StartWork              <= 1'b0;
            PhaseCfg.resetTime     <= ResetTime;
            PhaseCfg.waitToAcq     <= WaitToAcqTime;
            PhaseCfg.waitToConvB   <= WaitToConvBTime;
            PhaseCfg.convBWidth    <= ConvBWidth;
            PhaseCfg.waitToReadout <= WaitToReadoutTime;
            PhaseCfg.readoutWidth  <= ReadoutWidth;
            PhaseCfg.waitToEnd     <= WaitToEndTime;
            PhaseCfg.waitToNext    <= WaitToNextTime;
        end
        else if (wrEn)
        begin
            case (WbReq.adr)
                RegCtrl:          StartWork              <= WbReq.dat[0];
                RegResetTime:     PhaseCfg.resetTime     <= WbReq.dat[PhaseCntWidth-1:0];
                RegWaitToAcq:     PhaseCfg.waitToAcq     <= WbReq.dat[PhaseCntWidth-1:0];
                RegWaitToConvB:   PhaseCfg.waitToConvB   <= WbReq.dat[PhaseCntWidth-1:0];
                RegConvBWidth:    PhaseCfg.convBWidth    <= WbReq.dat[PhaseCntWidth-1:0];
                RegWaitToReadout: PhaseCfg.waitToReadout <= WbReq.dat[PhaseCntWidth-1:0];
                RegReadoutWidth:  PhaseCfg.readoutWidth  <= WbReq.dat[PhaseCntWidth-1:0];
                RegWaitToEnd:     PhaseCfg.waitToEnd     <= WbReq.dat[PhaseCntWidth-1:0];
                RegWaitToNext:    PhaseCfg.waitToNext    <= WbReq.dat[PhaseCntWidth-1:0];
                default:          ;                      // STATUS and holes ignore writes
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readback

    always_comb
    begin
        rdMux = '0;
        case (WbReq.adr)
            RegCtrl:
                rdMux[0] = StartWork;
            RegStatus:
            begin
                rdMux[3:0] = Phase;
                rdMux[4]   = Acqing;
            end
            RegResetTime:     rdMux[PhaseCntWidth-1:0] = PhaseCfg.resetTime;
            RegWaitToAcq:     rdMux[PhaseCntWidth-1:0] = PhaseCfg.waitToAcq;
            RegWaitToConvB:   rdMux[PhaseCntWidth-1:0] = PhaseCfg.waitToConvB;
            RegConvBWidth:    rdMux[PhaseCntWidth-1:0] = PhaseCfg.convBWidth;
            RegWaitToReadout: rdMux[PhaseCntWidth-1:0] = PhaseCfg.waitToReadout;
            RegReadoutWidth:  rdMux[PhaseCntWidth-1:0] = PhaseCfg.readoutWidth;
            RegWaitToEnd:     rdMux[PhaseCntWidth-1:0] = PhaseCfg.waitToEnd;
            RegWaitToNext:    rdMux[PhaseCntWidth-1:0] = PhaseCfg.waitToNext;
            default:          rdMux = '0;
        endcase
    end

    // Sampled together with ack
    always_ff @(posedge Clk)
    begin
        if (reqValid & ~ackQ)
            rdData <= rdMux;
    end

endmodule

// File: src/acqSequencer.sv
`timescale 1ns/1ns

module acqSequencer
    import skirocAcqPkg::*;
(
    input  logic     Clk,
    input  logic     Rst_N,
    input  logic     StartWork,
    input  phaseCfgT PhaseCfg,
    input  logic     ChipSatBFall,
    input  logic     EndReadoutRise,
    output acqPhaseT Phase,
    output asicCtrlT AsicCtrl,
    output logic     Acqing
);

    acqPhaseT                 phaseQ;
    acqPhaseT                 phaseNext;
    logic [PhaseCntWidth-1:0] timer;
    logic [PhaseCntWidth-1:0] timerLoad;
    logic                     timerDone;
    asicCtrlT                 ctrlNext;
    logic                     acqingNext;

    assign timerDone = (timer == '0);
    assign Phase     = phaseQ;

    ////////////////////////////////////////////////////////////////////////////
    // Round FSM

    always_comb
    begin
        phaseNext = phaseQ;
        case (phaseQ)
            Idle:
                if (StartWork)
                    phaseNext = Reset;
            Reset:
                // Only place a cleared start bit is honoured
                if (timerDone)
                    phaseNext = StartWork ? WaitToAcq : Idle;
            WaitToAcq:
                if (timerDone)
                    phaseNext = Acquire;
            Acquire:
                if (ChipSatBFall)               // No timeout here
                    phaseNext = WaitToConvB;
            WaitToConvB:
                if (timerDone)
                    phaseNext = ConvB;
            ConvB:
                if (timerDone)
                    phaseNext = WaitToReadout;
            WaitToReadout:
                if (timerDone)
                    phaseNext = Readout;
            Readout:
                if (timerDone)
                    phaseNext = WaitToEnd;
            WaitToEnd:
                if (EndReadoutRise || timerDone)  // Early exit on end of readout
                    phaseNext = WaitToNext;
            WaitToNext:
                if (timerDone)
                    phaseNext = Reset;
            default:
                phaseNext = Idle;
        endcase
    end

    // Duration of the phase being entered
    always_comb
    begin
        case (phaseNext)
            Reset:         timerLoad = PhaseCfg.resetTime;
            WaitToAcq:     timerLoad = PhaseCfg.waitToAcq;
            WaitToConvB:   timerLoad = PhaseCfg.waitToConvB;
            ConvB:         timerLoad = PhaseCfg.convBWidth;
            WaitToReadout: timerLoad = PhaseCfg.waitToReadout;
            Readout:       timerLoad = PhaseCfg.readoutWidth;
            WaitToEnd:     timerLoad = PhaseCfg.waitToEnd;
            WaitToNext:    timerLoad = PhaseCfg.waitToNext;
            default:       timerLoad = '0;
        endcase
    end

    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
        begin
            phaseQ <= Idle;
            timer  <= '0;
        end
        else
        begin
            phaseQ <= phaseNext;
            if (phaseNext != phaseQ)
                timer <= timerLoad;             // Reload on every entry
            else if (!timerDone)
                timer <= timer - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ASIC pins, one cycle behind the phase

    always_comb
    begin
        ctrlNext.startAcq     = 1'b0;
        ctrlNext.startConvB   = 1'b1;
        ctrlNext.startReadout = 1'b0;
        ctrlNext.pwrOnD       = 1'b0;
        ctrlNext.resetB       = 1'b1;
        acqingNext            = 1'b0;
        case (phaseQ)
            Reset:
            begin
                ctrlNext.resetB = 1'b0;
                ctrlNext.pwrOnD = 1'b1;
            end
            WaitToAcq, WaitToConvB, WaitToReadout:
                ctrlNext.pwrOnD = 1'b1;
            Acquire:
            begin
                ctrlNext.startAcq = 1'b1;
                ctrlNext.pwrOnD   = 1'b1;
                acqingNext        = 1'b1;
            end
            ConvB:
            begin
                ctrlNext.startConvB = 1'b0;
                ctrlNext.pwrOnD     = 1'b1;
            end
            Readout:
                ctrlNext.startReadout = 1'b1;   // Power pulsing off from here
            default:
                acqingNext = 1'b0;
        endcase
    end

    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
        begin
            AsicCtrl.startAcq     <= 1'b0;
            AsicCtrl.startConvB   <= 1'b1;
            AsicCtrl.startReadout <= 1'b0;
            AsicCtrl.pwrOnD       <= 1'b0;
            AsicCtrl.resetB       <= 1'b1;
            Acqing                <= 1'b0;
        end
        else
        begin
            AsicCtrl <= ctrlNext;
            Acqing   <= acqingNext;
        end
    end

endmodule

// File: src/skirocAcq.sv
`timescale 1ns/1ns

module skirocAcq
    import skirocAcqPkg::*;
#(
    // Power-up durations, 20 ns clock
    parameter logic [PhaseCntWidth-1:0] ResetTime         = 20'd25,      // 500 ns
    parameter logic [PhaseCntWidth-1:0] WaitToAcqTime     = 20'd50,      // 1 us
    parameter logic [PhaseCntWidth-1:0] WaitToConvBTime   = 20'd50,      // 1 us
    parameter logic [PhaseCntWidth-1:0] ConvBWidth        = 20'd2,
    parameter logic [PhaseCntWidth-1:0] WaitToReadoutTime = 20'd250000,  // 5 ms
    parameter logic [PhaseCntWidth-1:0] ReadoutWidth      = 20'd25,
    parameter logic [PhaseCntWidth-1:0] WaitToEndTime     = 20'd250000,  // 5 ms
    parameter logic [PhaseCntWidth-1:0] WaitToNextTime    = 20'd50
) (
    input  logic     Clk,
    input  logic     Rst_N,
    input  wbReqT    WbReq,
    output wbRspT    WbRsp,
    input  logic     ChipSatB,
    input  logic     EndReadout,
    output asicCtrlT AsicCtrl,
    output logic     Acqing
);

    logic     startWork;
    phaseCfgT phaseCfg;
    acqPhaseT phase;
    logic     chipSatBFall;
    logic     endReadoutRise;

    ////////////////////////////////////////////////////////////////////////////
    // Configuration registers

    timingRegs #(
        .ResetTime         (ResetTime),
        .WaitToAcqTime     (WaitToAcqTime),
        .WaitToConvBTime   (WaitToConvBTime),
        .ConvBWidth        (ConvBWidth),
        .WaitToReadoutTime (WaitToReadoutTime),
        .ReadoutWidth      (ReadoutWidth),
        .WaitToEndTime     (WaitToEndTime),
        .WaitToNextTime    (WaitToNextTime)
    ) i_timingRegs (
        .Clk       (Clk),
        .Rst_N     (Rst_N),
        .WbReq     (WbReq),
        .WbRsp     (WbRsp),
        .Phase     (phase),
        .Acqing    (Acqing),
        .StartWork (startWork),
        .PhaseCfg  (phaseCfg)
    );

    // ChipSatB rests high
    edgeSync #(.IdleLevel(1'b1)) i_chipSatBSync (
        .Clk   (Clk),
        .Rst_N (Rst_N),
        .Async (ChipSatB),
        .Rise  (),
        .Fall  (chipSatBFall)
    );

    edgeSync #(.IdleLevel(1'b0)) i_endReadoutSync (
        .Clk   (Clk),
        .Rst_N (Rst_N),
        .Async (EndReadout),
        .Rise  (endReadoutRise),
        .Fall  ()
    );

    acqSequencer i_acqSequencer (
        .Clk            (Clk),
        .Rst_N          (Rst_N),
        .StartWork      (startWork),
        .PhaseCfg       (phaseCfg),
        .ChipSatBFall   (chipSatBFall),
        .EndReadoutRise (endReadoutRise),
        .Phase          (phase),
        .AsicCtrl       (AsicCtrl),
        .Acqing         (Acqing)
    );

endmodule

// File: verification/skirocAcqTests.svh
////////////////////////////////////////////////////////////////////////////
// Wishbone classic master, request held until ack

task automatic busTransfer(input logic we, input logic [WbAdrWidth-1:0] adr,
                           input logic [WbDataWidth-1:0] wrData,
                           output logic [WbDataWidth-1:0] rdData);
    int waitCycles;
    waitCycles = 0;
    rdData     = '0;
    wbReq.cyc  = 1'b1;
    wbReq.stb  = 1'b1;
    wbReq.we   = we;
    wbReq.adr  = adr;
    wbReq.dat  = wrData;
    do
    begin
        @(negedge Clk);
        waitCycles++;
    end
    while (!wbRsp.ack && waitCycles < 16);
    if (!wbRsp.ack)
    begin
        errorCount++;
        $display("register port gave no ack at address %0d", adr);
    end
    else
    begin
        rdData = wbRsp.dat;
        checkEq(waitCycles, 1, "ack latency");
        @(negedge Clk);                       // Acknowledging edge has passed
        checkEq(wbRsp.ack, 1'b0, "ack held longer than one cycle");
    end
    wbReq = '0;
endtask

task automatic wbWrite(input logic [WbAdrWidth-1:0] adr, input logic [WbDataWidth-1:0] data);
    logic [WbDataWidth-1:0] unused;
    busTransfer(1'b1, adr, data, unused);
endtask

task automatic wbRead(input logic [WbAdrWidth-1:0] adr, output logic [WbDataWidth-1:0] data);
    busTransfer(1'b0, adr, '0, data);
endtask

task automatic programDurations();
    wbWrite(RegResetTime, ResetT);
    wbWrite(RegWaitToAcq, WaitToAcqT);
    wbWrite(RegWaitToConvB, WaitToConvBT);
    wbWrite(RegConvBWidth, ConvBT);
    wbWrite(RegWaitToReadout, WaitToReadoutT);
    wbWrite(RegReadoutWidth, ReadoutT);
    wbWrite(RegWaitToEnd, WaitToEndT);
    wbWrite(RegWaitToNext, WaitToNextT);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests

task automatic resetDefaults();
    logic [WbDataWidth-1:0] rd;
    int                     defaults [8] = '{25, 50, 50, 2, 250000, 25, 250000, 50};
    checkEq(asicCtrl.startAcq, 1'b0, "startAcq after reset");
    checkEq(asicCtrl.startConvB, 1'b1, "startConvB after reset");
    checkEq(asicCtrl.startReadout, 1'b0, "startReadout after reset");
    checkEq(asicCtrl.pwrOnD, 1'b0, "pwrOnD after reset");
    checkEq(asicCtrl.resetB, 1'b1, "resetB after reset");
    checkEq(acqing, 1'b0, "Acqing after reset");
    checkEq(wbRsp.ack, 1'b0, "ack after reset");
    wbRead(RegStatus, rd);
    checkEq(rd, 32'(Idle), "STATUS after reset");
    wbRead(RegCtrl, rd);
    checkEq(rd, 0, "CTRL after reset");
    for (int i = 0; i < 8; i++)
    begin
        wbRead(RegResetTime + 4'(i), rd);
        checkEq(rd, defaults[i], $sformatf("default of duration %0d", i));
    end
    reportTest("resetDefaults");
endtask

task automatic registerReadback();
    logic [WbDataWidth-1:0] rd;
    logic [WbDataWidth-1:0] values [8];
    for (int i = 0; i < 8; i++)
    begin
        values[i] = $urandom;
        wbWrite(RegResetTime + 4'(i), values[i]);
    end
    for (int i = 0; i < 8; i++)
    begin
        wbRead(RegResetTime + 4'(i), rd);
        checkEq(rd, 32'(values[i][PhaseCntWidth-1:0]), $sformatf("readback of duration %0d", i));
    end
    wbWrite(RegCtrl, 32'hffff_fffe);            // Upper bits only, sequencer stays idle
    wbRead(RegCtrl, rd);
    checkEq(rd, 0, "CTRL readback");
    wbRead(4'hc, rd);
    checkEq(rd, 0, "unmapped address");
    reportTest("registerReadback");
endtask

task automatic fullRound();
    int                     width;
    int                     guard;
    int                     acqDelay;
    logic                   prevPwr;
    logic [WbDataWidth-1:0] rd;
    programDurations();
    wbWrite(RegCtrl, 1);
    waitForPin(PinResetB, 1'b0, RoundCycles, "resetB fall", width);
    waitForPin(PinResetB, 1'b1, RoundCycles, "resetB rise", width);
    checkEq(width, ResetT + 1, "resetB low width");
    guard = 0;
    while (!asicCtrl.startAcq && guard < RoundCycles)
    begin
        checkEq(acqing, 1'b0, "Acqing before startAcq");
        @(negedge Clk);
        guard++;
    end
    checkEq(acqing, 1'b1, "Acqing rises with startAcq");
    while (asicCtrl.startAcq && guard < 2 * RoundCycles)
    begin
        checkEq(acqing, 1'b1, "Acqing during acquisition");
        @(negedge Clk);
        guard++;
    end
    checkEq(acqing, 1'b0, "Acqing falls with startAcq");
    // Two sync flops, edge register, phase and pin register
    acqDelay = int'(($time - satFallTime) / ClkPeriod);
    checkEq(acqDelay, 5, "Acqing end after ChipSatB fall");
    waitForPin(PinStartConvB, 1'b0, RoundCycles, "startConvB fall", width);
    waitForPin(PinStartConvB, 1'b1, RoundCycles, "startConvB rise", width);
    checkEq(width, ConvBT + 1, "startConvB low width");
    prevPwr = asicCtrl.pwrOnD;
    while (!asicCtrl.startReadout && guard < 3 * RoundCycles)
    begin
        prevPwr = asicCtrl.pwrOnD;
        @(negedge Clk);
        guard++;
    end
    checkEq(prevPwr, 1'b1, "pwrOnD before readout");
    checkEq(asicCtrl.pwrOnD, 1'b0, "pwrOnD falls with startReadout rise");
    waitForPin(PinStartReadout, 1'b0, RoundCycles, "startReadout fall", width);
    checkEq(width, ReadoutT + 1, "startReadout high width");
    wbRead(RegCtrl, rd);
    checkEq(rd, 1, "CTRL start bit readback");
    reportTest("fullRound");
endtask

task automatic earlyReadoutEnd();
    int cycles;
    endReadoutEnable = 1'b1;
    waitForPin(PinStartReadout, 1'b1, 2 * RoundCycles, "startReadout rise", cycles);
    waitForPin(PinStartReadout, 1'b0, RoundCycles, "startReadout fall", cycles);
    waitForPin(PinResetB, 1'b0, RoundCycles, "next resetB fall", cycles);
    checkEq(cycles < WaitToEndT + 1, 1'b1, $sformatf("early end gap of %0d cycles", cycles));
    reportTest("earlyReadoutEnd");
endtask

task automatic readoutTimeout();
    int cycles;
    endReadoutEnable = 1'b0;
    waitForPin(PinStartReadout, 1'b1, 2 * RoundCycles, "startReadout rise", cycles);
    waitForPin(PinStartReadout, 1'b0, RoundCycles, "startReadout fall", cycles);
    waitForPin(PinResetB, 1'b0, RoundCycles, "next resetB fall", cycles);
    checkEq(cycles >= WaitToEndT + WaitToNextT + 2, 1'b1,
            $sformatf("timeout gap of %0d cycles", cycles));
    reportTest("readoutTimeout");
endtask

task automatic stopSequencer();
    int                     cycles;
    int                     stray;
    logic [WbDataWidth-1:0] rd;
    waitForPin(PinStartAcq, 1'b1, 2 * RoundCycles, "startAcq rise", cycles);
    wbRead(RegStatus, rd);
    checkEq(rd, 32'h10 | 32'(Acquire), "STATUS during acquisition");   // Acqing in bit 4
    wbWrite(RegCtrl, 0);                        // Mid-round, honoured after the next Reset
    waitForPin(PinResetB, 1'b0, 2 * RoundCycles, "final resetB fall", cycles);
    waitForPin(PinResetB, 1'b1, RoundCycles, "final resetB rise", cycles);
    checkEq(cycles, ResetT + 1, "final resetB low width");
    stray = 0;
    repeat (RoundCycles)
    begin
        @(negedge Clk);
        if (!asicCtrl.resetB || asicCtrl.startAcq)
            stray++;
    end
    checkEq(stray, 0, "pin activity after stop");
    wbRead(RegStatus, rd);
    checkEq(rd, 32'(Idle), "STATUS after stop");
    reportTest("stopSequencer");
endtask

// File: verification/skirocAcqTb.sv
`timescale 1ns/1ns

module skirocAcqTb
    import skirocAcqPkg::*;
();

    localparam int ClkPeriod      = 4;
    // Short durations used for every round
    localparam int ResetT         = 3;
    localparam int WaitToAcqT     = 4;
    localparam int WaitToConvBT   = 3;
    localparam int ConvBT         = 2;
    localparam int WaitToReadoutT = 5;
    localparam int ReadoutT       = 3;
    localparam int WaitToEndT     = 60;
    localparam int WaitToNextT    = 4;
    localparam int SatDelay       = 6;     // startAcq rise to ChipSatB fall
    localparam int EndDelay       = 4;     // startReadout fall to EndReadout rise
    localparam int RoundCycles    = ResetT + WaitToAcqT + WaitToConvBT + ConvBT
                                    + WaitToReadoutT + ReadoutT + WaitToEndT + WaitToNextT
                                    + SatDelay + 16;
    localparam int TestRounds     = 8;
    localparam int BusCycles      = 300;
    localparam int WatchdogCycles = 2 * TestRounds * RoundCycles + BusCycles + 200;

    localparam int PinStartAcq     = 0;
    localparam int PinStartConvB   = 1;
    localparam int PinStartReadout = 2;
    localparam int PinPwrOnD       = 3;
    localparam int PinResetB       = 4;

    logic     Clk;
    logic     Rst_N;
    wbReqT    wbReq;
    wbRspT    wbRsp;
    logic     chipSatB;
    logic     endReadout;
    asicCtrlT asicCtrl;
    logic     acqing;
    logic     endReadoutEnable;
    time      satFallTime;
    int       errorCount     = 0;
    int       checkCount     = 0;
    int       testCount      = 0;
    int       reportedErrors = 0;

    skirocAcq i_skirocAcq (
        .Clk        (Clk),
        .Rst_N      (Rst_N),
        .WbReq      (wbReq),
        .WbRsp      (wbRsp),
        .ChipSatB   (chipSatB),
        .EndReadout (endReadout),
        .AsicCtrl   (asicCtrl),
        .Acqing     (acqing)
    );

    initial
    begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // ASIC model

    always
    begin
        @(posedge asicCtrl.startAcq);
        repeat (SatDelay) @(negedge Clk);
        chipSatB    = 1'b0;
        satFallTime = $time;
        @(posedge asicCtrl.startConvB);       // Released after the ConvB pulse
        @(negedge Clk);
        chipSatB = 1'b1;
    end

    always
    begin
        @(negedge asicCtrl.startReadout);
        if (endReadoutEnable)
        begin
            repeat (EndDelay) @(negedge Clk);
            endReadout = 1'b1;
            repeat (2) @(negedge Clk);
            endReadout = 1'b0;
        end
    end

    initial
    begin
        repeat (WatchdogCycles) @(posedge Clk);
        $display("watchdog expired after %0d cycles, the sequence did not finish",
                 WatchdogCycles);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking helpers

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    function automatic logic pinLevel(input int pin);
        case (pin)
            PinStartAcq:     return asicCtrl.startAcq;
            PinStartConvB:   return asicCtrl.startConvB;
            PinStartReadout: return asicCtrl.startReadout;
            PinPwrOnD:       return asicCtrl.pwrOnD;
            default:         return asicCtrl.resetB;
        endcase
    endfunction

    // Counts falling edges until the pin shows the level
    task automatic waitForPin(input int pin, input logic level, input int limit,
                              input string what, output int cycles);
        cycles = 0;
        while (pinLevel(pin) !== level && cycles < limit)
        begin
            @(negedge Clk);
            cycles++;
        end
        if (pinLevel(pin) !== level)
        begin
            errorCount++;
            $display("%s did not happen within %0d cycles", what, limit);
        end
    endtask

    task automatic reportTest(input string name);
        $display("%-18s %s, %0d errors", name,
                 (errorCount == reportedErrors) ? "ok" : "FAILED", errorCount - reportedErrors);
        reportedErrors = errorCount;
        testCount++;
    endtask

    `include "skirocAcqTests.svh"

    initial
    begin
        void'($urandom(32'hd15c_cb36));
        Rst_N            = 1'b0;
        wbReq            = '0;
        chipSatB         = 1'b1;
        endReadout       = 1'b0;
        endReadoutEnable = 1'b0;
        repeat (2) @(negedge Clk);
        Rst_N = 1'b1;
        resetDefaults();
        registerReadback();
        fullRound();
        earlyReadoutEnd();
        readoutTimeout();
        stopSequencer();
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: skirocAcq.f
+incdir+verification
src/skirocAcqPkg.sv
src/edgeSync.sv
src/timingRegs.sv
src/acqSequencer.sv
src/skirocAcq.sv
verification/skirocAcqTb.sv

// File: Bender.yml
package:
  name: skirocAcq

sources:
  - src/skirocAcqPkg.sv
  - src/edgeSync.sv
  - src/timingRegs.sv
  - src/acqSequencer.sv
  - src/skirocAcq.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/skirocAcqTb.sv
